// ==== design/usb_pkg.sv ====
`default_nettype none

package usb_pkg;

  // USB packet identifiers, low nibble of the PID byte
  typedef enum logic [3:0] {
    PID_OUT   = 4'b0001,
    PID_IN    = 4'b1001,
    PID_SOF   = 4'b0101,
    PID_DATA0 = 4'b0011,
    PID_DATA1 = 4'b1011,
    PID_ACK   = 4'b0010,
    PID_NAK   = 4'b1010
  } pid_t;

  // What the decoder is currently receiving
  typedef enum logic [1:0] {
    PKT_NONE,
    PKT_TOKEN,
    PKT_DATA
  } pkt_kind_t;

  localparam logic [7:0] ULPI_TX_CMD = 8'h40;  // Transmit command, PID in bits 3:0

  // Registers run LSB first, the order the bits appear on the bus
  localparam logic [4:0]  CRC5_INIT     = 5'h1f;
  localparam logic [15:0] CRC16_INIT    = 16'hffff;
  localparam logic [4:0]  CRC5_RESIDUE  = 5'b00110;  // Reflected form of 01100
  localparam logic [15:0] CRC16_RESIDUE = 16'hb001;  // Reflected form of 800d

  // x^5 + x^2 + 1, reflected
  function automatic logic [4:0] crc5_next(input logic [4:0] crc, input logic [7:0] data);
    logic [4:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 5'b10100;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

  // x^16 + x^15 + x^2 + 1, reflected
  function automatic logic [15:0] crc16_next(input logic [15:0] crc, input logic [7:0] data);
    logic [15:0] c;
    c = crc;
    for (int i = 0; i < 8; i++) begin
      if (c[0] ^ data[i]) begin
        c = (c >> 1) ^ 16'ha001;
      end else begin
        c = c >> 1;
      end
    end
    return c;
  endfunction

endpackage

`default_nettype wire

// ==== design/ulpi_rx_decoder.sv ====
`default_nettype none

module ulpi_rx_decoder
  import usb_pkg::*;
(
  input  wire        clock,
  input  wire        areset_n,
  input  wire        ulpi_dir_i,
  input  wire        ulpi_nxt_i,
  input  wire  [7:0] ulpi_data_i,
  output logic       tok_out_o,
  output logic       sof_o,
  output logic [6:0] tok_addr_o,
  output logic [3:0] tok_endp_o,
  output logic       data_start_o,
  output pid_t       data_pid_o,
  output logic       byte_valid_o,
  output logic [7:0] byte_o,
  output logic       data_end_o,
  output logic       crc_ok_o
);

  logic        dir_q;
  logic        turn_w;
  logic        rx_byte_w;
  logic        rx_end_w;
  logic [2:0]  cnt_q;       // Bytes of this packet, saturates at 7
  pkt_kind_t   kind_q;
  pid_t        pid_q;
  logic [1:0]  fill_q;      // Occupancy of the CRC delay line
  logic [7:0]  dly0_q;
  logic [7:0]  dly1_q;
  logic [4:0]  crc5_q;
  logic [15:0] crc16_q;

  assign turn_w    = ulpi_dir_i && !dir_q;
  assign rx_byte_w = ulpi_dir_i && dir_q && ulpi_nxt_i;  // RX CMD cycles have nxt low
  assign rx_end_w  = !ulpi_dir_i && dir_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      dir_q        <= 1'b0;
      cnt_q        <= '0;
      kind_q       <= PKT_NONE;
      pid_q        <= PID_OUT;
      fill_q       <= '0;
      tok_out_o    <= 1'b0;
      sof_o        <= 1'b0;
      data_start_o <= 1'b0;
      data_pid_o   <= PID_DATA0;
      byte_valid_o <= 1'b0;
      data_end_o   <= 1'b0;
      crc_ok_o     <= 1'b0;
    end else begin
      dir_q        <= ulpi_dir_i;
      tok_out_o    <= 1'b0;
      sof_o        <= 1'b0;
      data_start_o <= 1'b0;
      byte_valid_o <= 1'b0;
      data_end_o   <= 1'b0;

      if (turn_w) begin
        cnt_q  <= '0;
        kind_q <= PKT_NONE;
      end else if (rx_byte_w) begin
        if (cnt_q != 3'd7) begin
          cnt_q <= cnt_q + 3'd1;
        end
        if (cnt_q == 3'd0) begin
          pid_q  <= pid_t'(ulpi_data_i[3:0]);
          fill_q <= '0;
          // PID byte carries its own complement in the upper nibble
          if (ulpi_data_i[7:4] == ~ulpi_data_i[3:0]) begin
            case (ulpi_data_i[3:0])
              PID_OUT, PID_SOF:     kind_q <= PKT_TOKEN;
              PID_DATA0, PID_DATA1: kind_q <= PKT_DATA;
              default:              kind_q <= PKT_NONE;
            endcase
          end else begin
            kind_q <= PKT_NONE;
          end
        end else if (kind_q == PKT_DATA) begin
          if (cnt_q == 3'd1) begin
            data_start_o <= 1'b1;
            data_pid_o   <= pid_q;
          end
          // Only release a byte once two newer ones sit behind it
          byte_valid_o <= (fill_q == 2'd2);
          if (fill_q != 2'd2) begin
            fill_q <= fill_q + 2'd1;
          end
        end
      end else if (rx_end_w) begin
        case (kind_q)
          PKT_TOKEN: begin
            if (cnt_q == 3'd3 && crc5_q == CRC5_RESIDUE) begin
              tok_out_o <= (pid_q == PID_OUT);
              sof_o     <= (pid_q == PID_SOF);
            end
          end
          PKT_DATA: begin
            data_end_o <= 1'b1;
            crc_ok_o   <= (cnt_q >= 3'd3) && (crc16_q == CRC16_RESIDUE);
          end
          default: ;
        endcase
        kind_q <= PKT_NONE;
      end
    end
  end

  // Datapath, CRC residues and the two-byte delay line
  always_ff @(posedge clock) begin
    if (rx_byte_w) begin
      if (cnt_q == 3'd0) begin
        crc5_q  <= CRC5_INIT;
        crc16_q <= CRC16_INIT;
      end else begin
        crc5_q  <= crc5_next(crc5_q, ulpi_data_i);
        crc16_q <= crc16_next(crc16_q, ulpi_data_i);
      end
      if (kind_q == PKT_TOKEN && cnt_q == 3'd1) begin
        tok_addr_o    <= ulpi_data_i[6:0];
        tok_endp_o[0] <= ulpi_data_i[7];
      end
      if (kind_q == PKT_TOKEN && cnt_q == 3'd2) begin
        tok_endp_o[3:1] <= ulpi_data_i[2:0];
      end
      dly1_q <= dly0_q;
      dly0_q <= ulpi_data_i;
      byte_o <= dly1_q;  // Qualified by byte_valid_o
    end
  end

endmodule

`default_nettype wire

// ==== design/bulk_out_transactor.sv ====
`default_nettype none

module bulk_out_transactor
  import usb_pkg::*;
#(
  parameter logic [6:0] DEVICE_ADDR = 7'd5,
  parameter logic [3:0] ENDPOINT    = 4'd1
) (
  input  wire        clock,
  input  wire        areset_n,
  input  wire        tok_out_i,
  input  wire  [6:0] tok_addr_i,
  input  wire  [3:0] tok_endp_i,
  input  wire        data_start_i,
  input  wire  pid_t data_pid_i,
  input  wire        byte_valid_i,
  input  wire  [7:0] byte_i,
  input  wire        data_end_i,
  input  wire        crc_ok_i,
  input  wire        buf_full_i,
  input  wire        hs_busy_i,
  output logic       wr_en_o,
  output logic [7:0] wr_data_o,
  output logic       commit_o,
  output logic       discard_o,
  output logic       hs_send_o,
  output pid_t       hs_pid_o
);

  logic armed_q;      // Matching OUT token seen
  logic rx_active_q;  // Data packet for us in progress
  logic nak_q;        // Buffer was occupied when the packet began
  logic toggle_q;     // Low while DATA0 is expected
  logic match_w;
  pid_t expect_w;

  assign match_w   = (tok_addr_i == DEVICE_ADDR) && (tok_endp_i == ENDPOINT);
  assign expect_w  = toggle_q ? PID_DATA1 : PID_DATA0;
  assign wr_en_o   = byte_valid_i && rx_active_q && !nak_q;
  assign wr_data_o = byte_i;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      armed_q     <= 1'b0;
      rx_active_q <= 1'b0;
      nak_q       <= 1'b0;
      toggle_q    <= 1'b0;
      commit_o    <= 1'b0;
      discard_o   <= 1'b0;
      hs_send_o   <= 1'b0;
      hs_pid_o    <= PID_NAK;
    end else begin
      commit_o  <= 1'b0;
      discard_o <= 1'b0;
      hs_send_o <= 1'b0;

      if (tok_out_i) begin
        armed_q <= match_w;  // Any other OUT token disarms
      end

      if (data_start_i && armed_q) begin
        armed_q     <= 1'b0;
        rx_active_q <= 1'b1;
        nak_q       <= buf_full_i;
      end

      if (data_end_i && rx_active_q) begin
        rx_active_q <= 1'b0;
        if (!crc_ok_i) begin
          discard_o <= 1'b1;  // Corrupt packet, stay silent
        end else begin
          if (!hs_busy_i) begin
            hs_send_o <= 1'b1;
            hs_pid_o  <= nak_q ? PID_NAK : PID_ACK;
          end
          if (nak_q || data_pid_i != expect_w) begin
            // Retransmission of the last packet is acknowledged but dropped
            discard_o <= 1'b1;
          end else begin
            commit_o <= 1'b1;
            toggle_q <= !toggle_q;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== design/packet_buffer.sv ====
`default_nettype none

module packet_buffer #(
  parameter int unsigned MAX_PACKET = 64
) (
  input  wire        clock,
  input  wire        areset_n,
  input  wire        wr_en_i,
  input  wire  [7:0] wr_data_i,
  input  wire        commit_i,
  input  wire        discard_i,
  input  wire        m_axis_tready_i,
  output logic       full_o,
  output logic       m_axis_tvalid_o,
  output logic [7:0] m_axis_tdata_o,
  output logic       m_axis_tlast_o
);

  localparam int ADDR_W = $clog2(MAX_PACKET);
  localparam int CNT_W  = $clog2(MAX_PACKET + 1);
  localparam logic [CNT_W-1:0] MAX_CNT = CNT_W'(MAX_PACKET);
  localparam logic [CNT_W-1:0] ONE     = CNT_W'(1);

  logic [7:0]       mem_q [MAX_PACKET];
  logic [CNT_W-1:0] wr_cnt_q;
  logic [CNT_W-1:0] len_q;
  logic [CNT_W-1:0] rd_ptr_q;  // Next byte to load into the output register
  logic             store_w;
  logic             load_w;
  logic             step_w;
  logic             done_w;

  assign store_w = wr_en_i && !full_o && (wr_cnt_q < MAX_CNT);  // Overflow bytes dropped
  assign load_w  = commit_i && (wr_cnt_q != '0);
  assign step_w  = m_axis_tvalid_o && m_axis_tready_i;
  assign done_w  = step_w && m_axis_tlast_o;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      wr_cnt_q        <= '0;
      rd_ptr_q        <= '0;
      full_o          <= 1'b0;
      m_axis_tvalid_o <= 1'b0;
    end else begin
      if (commit_i || discard_i) begin
        wr_cnt_q <= '0;
      end else if (store_w) begin
        wr_cnt_q <= wr_cnt_q + ONE;
      end

      if (load_w) begin
        full_o          <= 1'b1;
        m_axis_tvalid_o <= 1'b1;
        rd_ptr_q        <= ONE;
      end else if (done_w) begin
        full_o          <= 1'b0;
        m_axis_tvalid_o <= 1'b0;
      end else if (step_w) begin
        rd_ptr_q <= rd_ptr_q + ONE;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (store_w) begin
      mem_q[wr_cnt_q[ADDR_W-1:0]] <= wr_data_i;
    end
    if (load_w) begin
      m_axis_tdata_o <= mem_q[0];
      m_axis_tlast_o <= (wr_cnt_q == ONE);
      len_q          <= wr_cnt_q;
    end else if (step_w && !m_axis_tlast_o) begin
      m_axis_tdata_o <= mem_q[rd_ptr_q[ADDR_W-1:0]];
      m_axis_tlast_o <= (rd_ptr_q + ONE) == len_q;
    end
  end

endmodule

`default_nettype wire

// ==== design/ulpi_handshake_tx.sv ====
`default_nettype none

module ulpi_handshake_tx
  import usb_pkg::*;
(
  input  wire        clock,
  input  wire        areset_n,
  input  wire        send_i,
  input  wire  pid_t pid_i,
  input  wire        ulpi_dir_i,
  input  wire        ulpi_nxt_i,
  output logic       busy_o,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_data_oe_o,
  output logic       ulpi_stp_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_CMD,   // TX CMD on the bus until the PHY takes it
    ST_STOP
  } state_t;

  state_t state_q;
  pid_t   pid_q;

  assign busy_o         = (state_q != ST_IDLE);
  assign ulpi_data_oe_o = busy_o && !ulpi_dir_i;  // PHY owns the bus while dir is high
  assign ulpi_stp_o     = (state_q == ST_STOP);
  assign ulpi_data_o    = (state_q == ST_CMD) ? (ULPI_TX_CMD | {4'h0, pid_q}) : 8'h00;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (send_i) state_q <= ST_CMD;
        ST_CMD:  if (!ulpi_dir_i && ulpi_nxt_i) state_q <= ST_STOP;
        default: state_q <= ST_IDLE;  // Stop lasts a single cycle
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (send_i && state_q == ST_IDLE) begin
      pid_q <= pid_i;
    end
  end

endmodule

`default_nettype wire

// ==== design/ulpi_bulk_out_bridge.sv ====
`default_nettype none

module ulpi_bulk_out_bridge
  import usb_pkg::*;
#(
  parameter logic [6:0]  DEVICE_ADDR = 7'd5,
  parameter logic [3:0]  ENDPOINT    = 4'd1,
  parameter int unsigned MAX_PACKET  = 64
) (
  input  wire        clock,
  input  wire        areset_n,
  input  wire        ulpi_dir_i,
  input  wire        ulpi_nxt_i,
  input  wire  [7:0] ulpi_data_i,
  output logic [7:0] ulpi_data_o,
  output logic       ulpi_data_oe_o,
  output logic       ulpi_stp_o,
  output logic       m_axis_tvalid_o,
  input  wire        m_axis_tready_i,
  output logic [7:0] m_axis_tdata_o,
  output logic       m_axis_tlast_o,
  output logic       usb_sof_o,
  output logic       crc_err_o
);

  logic       tok_out_w;
  logic [6:0] tok_addr_w;
  logic [3:0] tok_endp_w;
  logic       data_start_w;
  pid_t       data_pid_w;
  logic       byte_valid_w;
  logic [7:0] byte_w;
  logic       data_end_w;
  logic       crc_ok_w;
  logic       wr_en_w;
  logic [7:0] wr_data_w;
  logic       commit_w;
  logic       discard_w;
  logic       buf_full_w;
  logic       hs_send_w;
  pid_t       hs_pid_w;
  logic       hs_busy_w;

  assign crc_err_o = data_end_w && !crc_ok_w;

  ulpi_rx_decoder u_decoder (
    .clock        (clock),
    .areset_n     (areset_n),
    .ulpi_dir_i   (ulpi_dir_i),
    .ulpi_nxt_i   (ulpi_nxt_i),
    .ulpi_data_i  (ulpi_data_i),
    .tok_out_o    (tok_out_w),
    .sof_o        (usb_sof_o),
    .tok_addr_o   (tok_addr_w),
    .tok_endp_o   (tok_endp_w),
    .data_start_o (data_start_w),
    .data_pid_o   (data_pid_w),
    .byte_valid_o (byte_valid_w),
    .byte_o       (byte_w),
    .data_end_o   (data_end_w),
    .crc_ok_o     (crc_ok_w)
  );

  bulk_out_transactor #(
    .DEVICE_ADDR (DEVICE_ADDR),
    .ENDPOINT    (ENDPOINT)
  ) u_transactor (
    .clock        (clock),
    .areset_n     (areset_n),
    .tok_out_i    (tok_out_w),
    .tok_addr_i   (tok_addr_w),
    .tok_endp_i   (tok_endp_w),
    .data_start_i (data_start_w),
    .data_pid_i   (data_pid_w),
    .byte_valid_i (byte_valid_w),
    .byte_i       (byte_w),
    .data_end_i   (data_end_w),
    .crc_ok_i     (crc_ok_w),
    .buf_full_i   (buf_full_w),
    .hs_busy_i    (hs_busy_w),
    .wr_en_o      (wr_en_w),
    .wr_data_o    (wr_data_w),
    .commit_o     (commit_w),
    .discard_o    (discard_w),
    .hs_send_o    (hs_send_w),
    .hs_pid_o     (hs_pid_w)
  );

  // Holds one accepted packet until the stream has drained it
  packet_buffer #(
    .MAX_PACKET (MAX_PACKET)
  ) u_buffer (
    .clock           (clock),
    .areset_n        (areset_n),
    .wr_en_i         (wr_en_w),
    .wr_data_i       (wr_data_w),
    .commit_i        (commit_w),
    .discard_i       (discard_w),
    .m_axis_tready_i (m_axis_tready_i),
    .full_o          (buf_full_w),
    .m_axis_tvalid_o (m_axis_tvalid_o),
    .m_axis_tdata_o  (m_axis_tdata_o),
    .m_axis_tlast_o  (m_axis_tlast_o)
  );

  ulpi_handshake_tx u_handshake (
    .clock          (clock),
    .areset_n       (areset_n),
    .send_i         (hs_send_w),
    .pid_i          (hs_pid_w),
    .ulpi_dir_i     (ulpi_dir_i),
    .ulpi_nxt_i     (ulpi_nxt_i),
    .busy_o         (hs_busy_w),
    .ulpi_data_o    (ulpi_data_o),
    .ulpi_data_oe_o (ulpi_data_oe_o),
    .ulpi_stp_o     (ulpi_stp_o)
  );

endmodule

`default_nettype wire

// ==== test/ulpi_bulk_out_assert.sv ====
`default_nettype none

module ulpi_bulk_out_assert (
  input wire       clock,
  input wire       areset_n,
  input wire       ulpi_dir_i,
  input wire       ulpi_nxt_i,
  input wire       ulpi_data_oe_i,
  input wire       ulpi_stp_i,
  input wire       tvalid_i,
  input wire       tready_i,
  input wire [7:0] tdata_i,
  input wire       tlast_i,
  input wire       crc_err_i,
  input wire       hs_send_i
);

  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_count = 0;

  // Stalled stream beat holds its payload
  stream_hold: assert property (@(posedge clock) disable iff (!areset_n)
    tvalid_i && !tready_i |=> tvalid_i && $stable(tdata_i) && $stable(tlast_i))
  else begin
    fail_count = fail_count + 1;
    $error("Stream beat changed before tready");
  end

  stp_single: assert property (@(posedge clock) disable iff (!areset_n)
    ulpi_stp_i |=> !ulpi_stp_i)
  else begin
    fail_count = fail_count + 1;
    $error("ulpi_stp_o held longer than one cycle");
  end

  // Stop only after the PHY accepted the command
  stp_after_nxt: assert property (@(posedge clock) disable iff (!areset_n)
    ulpi_stp_i |-> $past(ulpi_nxt_i && ulpi_data_oe_i))
  else begin
    fail_count = fail_count + 1;
    $error("ulpi_stp_o without a preceding nxt under oe");
  end

  bus_owner: assert property (@(posedge clock) disable iff (!areset_n)
    ulpi_dir_i |-> !ulpi_data_oe_i)
  else begin
    fail_count = fail_count + 1;
    $error("Bus driven while the PHY holds dir");
  end

  silent_on_crc_err: assert property (@(posedge clock) disable iff (!areset_n)
    crc_err_i |=> !hs_send_i)
  else begin
    fail_count = fail_count + 1;
    $error("Handshake requested after a CRC16 error");
  end

endmodule

bind ulpi_bulk_out_bridge ulpi_bulk_out_assert u_assert (
  .clock          (clock),
  .areset_n       (areset_n),
  .ulpi_dir_i     (ulpi_dir_i),
  .ulpi_nxt_i     (ulpi_nxt_i),
  .ulpi_data_oe_i (ulpi_data_oe_o),
  .ulpi_stp_i     (ulpi_stp_o),
  .tvalid_i       (m_axis_tvalid_o),
  .tready_i       (m_axis_tready_i),
  .tdata_i        (m_axis_tdata_o),
  .tlast_i        (m_axis_tlast_o),
  .crc_err_i      (crc_err_o),
  .hs_send_i      (hs_send_w)
);

`default_nettype wire

// ==== test/ulpi_bulk_out_tb.sv ====
`default_nettype none

module ulpi_bulk_out_tb
  import usb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [6:0] DEV_ADDR = 7'd5;
  localparam logic [3:0] DEV_ENDP = 4'd1;
  localparam int         TIMEOUT  = 200;  // Cycles per wait loop

  logic       clock;
  logic       areset_n;
  logic       ulpi_dir;
  logic       ulpi_nxt;
  logic [7:0] ulpi_data_in;
  logic [7:0] ulpi_data_out;
  logic       ulpi_data_oe;
  logic       ulpi_stp;
  logic       tvalid;
  logic       tready = 1'b0;
  logic [7:0] tdata;
  logic       tlast;
  logic       usb_sof;
  logic       crc_err;

  integer     seed = 32'h93085ed0;
  integer     ready_seed = ~32'h93085ed0;  // Separate stream for the sink
  logic [7:0] tx_bytes [$];                // Packet under construction
  logic [8:0] exp_mem [256];               // {tlast, data} still to arrive
  int         exp_wr;
  int         exp_rd;
  bit         hold_ready;
  int         errors;
  int         sink_errors;
  int         sof_count;
  int         crc_err_count;
  int         tests_failed;
  int         mark;

  ulpi_bulk_out_bridge #(
    .DEVICE_ADDR (DEV_ADDR),
    .ENDPOINT    (DEV_ENDP),
    .MAX_PACKET  (64)
  ) dut (
    .clock           (clock),
    .areset_n        (areset_n),
    .ulpi_dir_i      (ulpi_dir),
    .ulpi_nxt_i      (ulpi_nxt),
    .ulpi_data_i     (ulpi_data_in),
    .ulpi_data_o     (ulpi_data_out),
    .ulpi_data_oe_o  (ulpi_data_oe),
    .ulpi_stp_o      (ulpi_stp),
    .m_axis_tvalid_o (tvalid),
    .m_axis_tready_i (tready),
    .m_axis_tdata_o  (tdata),
    .m_axis_tlast_o  (tlast),
    .usb_sof_o       (usb_sof),
    .crc_err_o       (crc_err)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  // Stream sink with random back-pressure
  always @(negedge clock) begin
    logic [8:0] want;
    tready = !hold_ready && ($random(ready_seed) % 2 != 0);
    if (usb_sof) sof_count++;
    if (crc_err) crc_err_count++;
    if (tvalid && tready) begin
      if (exp_rd == exp_wr) begin
        sink_errors++;
        $display("At %0t ns: stream byte %h arrived while none was expected", $time, tdata);
      end else begin
        want = exp_mem[exp_rd % 256];
        exp_rd++;
        if (tdata !== want[7:0]) begin
          sink_errors++;
          $display("FAILED at %0t ns: m_axis_tdata_o got %h expected %h", $time, tdata, want[7:0]);
        end
        if (tlast !== want[8]) begin
          sink_errors++;
          $display("FAILED at %0t ns: m_axis_tlast_o got %b expected %b", $time, tlast, want[8]);
        end
      end
    end
  end

  function automatic int total_errors();
    return errors + sink_errors + int'(dut.u_assert.fail_count);
  endfunction

  task automatic build_token(input pid_t pid, input logic [6:0] addr, input logic [3:0] endp);
    logic [7:0] b1;
    logic [7:0] b2;
    b1 = {endp[0], addr};
    b2 = 8'h00;
    // Search the CRC5 field that leaves the good residue
    for (int c = 0; c < 32; c++) begin
      if (crc5_next(crc5_next(CRC5_INIT, b1), {c[4:0], endp[3:1]}) == CRC5_RESIDUE) begin
        b2 = {c[4:0], endp[3:1]};
      end
    end
    tx_bytes.delete();
    tx_bytes.push_back({~pid, pid});
    tx_bytes.push_back(b1);
    tx_bytes.push_back(b2);
  endtask

  task automatic build_data(input pid_t pid, input int len, input bit corrupt, input bit accept);
    logic [15:0] crc;
    logic [7:0]  b;
    crc = CRC16_INIT;
    tx_bytes.delete();
    tx_bytes.push_back({~pid, pid});
    for (int i = 0; i < len; i++) begin
      b = 8'($random(seed));
      crc = crc16_next(crc, b);
      tx_bytes.push_back(b);
      if (accept) begin
        exp_mem[exp_wr % 256] = {i == len - 1, b};
        exp_wr++;
      end
    end
    crc = ~crc;  // Sent inverted with the low byte first
    if (corrupt) crc[3] = ~crc[3];
    tx_bytes.push_back(crc[7:0]);
    tx_bytes.push_back(crc[15:8]);
  endtask

  // PHY side of a receive with turnaround and random RX CMD gaps
  task automatic drive_packet();
    int gap;
    @(negedge clock);
    ulpi_dir = 1'b1;
    ulpi_nxt = 1'b0;
    for (int i = 0; i < tx_bytes.size(); i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(negedge clock);
        ulpi_nxt     = 1'b0;
        ulpi_data_in = 8'h4d;
      end
      @(negedge clock);
      ulpi_nxt     = 1'b1;
      ulpi_data_in = tx_bytes[i];
    end
    @(negedge clock);
    ulpi_dir     = 1'b0;
    ulpi_nxt     = 1'b0;
    ulpi_data_in = 8'h00;
  endtask

  task automatic check_handshake(input pid_t pid);
    int         n;
    logic [7:0] want;
    want = ULPI_TX_CMD | {4'h0, pid};
    // PHY reports line state while the command waits for the bus
    @(negedge clock);
    ulpi_dir     = 1'b1;
    ulpi_data_in = 8'h4d;
    repeat (3) @(negedge clock);
    ulpi_dir     = 1'b0;
    ulpi_data_in = 8'h00;
    n = 0;
    @(negedge clock);
    while (!ulpi_data_oe && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (!ulpi_data_oe) begin
      errors++;
      $display("At %0t ns: no handshake transmit command appeared", $time);
    end else begin
      if (ulpi_data_out !== want) begin
        errors++;
        $display("FAILED at %0t ns: ulpi_data_o got %h expected %h", $time, ulpi_data_out, want);
      end
      ulpi_nxt = 1'b1;  // PHY takes the command
      @(negedge clock);
      ulpi_nxt = 1'b0;
      if (ulpi_stp !== 1'b1) begin
        errors++;
        $display("FAILED at %0t ns: ulpi_stp_o got %b expected 1", $time, ulpi_stp);
      end
    end
  endtask

  task automatic check_silence();
    repeat (12) begin
      @(negedge clock);
      if (ulpi_data_oe) begin
        errors++;
        $display("At %0t ns: the device drove the bus where no handshake belongs", $time);
      end
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while ((exp_rd != exp_wr || tvalid) && n < TIMEOUT) begin
      @(negedge clock);
      n++;
    end
    if (exp_rd != exp_wr || tvalid) begin
      errors++;
      $display("At %0t ns: stream still owes %0d bytes", $time, exp_wr - exp_rd);
    end
  endtask

  task automatic report_test(input int num, input string name);
    int n;
    n = total_errors() - mark;
    if (n != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", num, name, (n == 0) ? "passed" : "failed", n);
    mark = total_errors();
  endtask

  initial begin
    int sof_before;
    int crc_before;
    areset_n     = 1'b0;
    ulpi_dir     = 1'b0;
    ulpi_nxt     = 1'b0;
    ulpi_data_in = 8'h00;
    hold_ready   = 1'b0;
    repeat (5) @(negedge clock);
    areset_n = 1'b1;
    @(negedge clock);
    if (ulpi_stp || ulpi_data_oe || tvalid || usb_sof || crc_err) begin
      errors++;
      $display("At %0t ns: outputs not idle after reset", $time);
    end
    mark = total_errors();

    build_token(PID_OUT, DEV_ADDR, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA0, 8, 1'b0, 1'b1);
    drive_packet();
    check_handshake(PID_ACK);
    wait_drained();
    report_test(1, "DATA0 acknowledged and streamed");

    build_token(PID_OUT, DEV_ADDR, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA0, 5, 1'b0, 1'b0);  // Repeat of the last toggle
    drive_packet();
    check_handshake(PID_ACK);
    check_silence();
    report_test(2, "retransmitted DATA0 acknowledged and dropped");

    hold_ready = 1'b1;
    build_token(PID_OUT, DEV_ADDR, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA1, 6, 1'b0, 1'b1);
    drive_packet();
    check_handshake(PID_ACK);
    build_token(PID_OUT, DEV_ADDR, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA0, 4, 1'b0, 1'b0);
    drive_packet();
    check_handshake(PID_NAK);
    hold_ready = 1'b0;
    wait_drained();
    check_silence();
    report_test(3, "packet on a full buffer answered with NAK");

    crc_before = crc_err_count;
    build_token(PID_OUT, DEV_ADDR, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA0, 7, 1'b1, 1'b0);
    drive_packet();
    check_silence();
    if (crc_err_count - crc_before != 1) begin
      errors++;
      $display("FAILED at %0t ns: crc_err_o pulses got %0d expected 1",
               $time, crc_err_count - crc_before);
    end
    report_test(4, "bad CRC16 flagged without handshake");

    build_token(PID_OUT, DEV_ADDR + 7'd1, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA0, 3, 1'b0, 1'b0);
    drive_packet();
    check_silence();
    sof_before = sof_count;
    build_token(PID_SOF, 7'h2a, 4'h3);  // Frame number in the token fields
    drive_packet();
    repeat (4) @(negedge clock);
    if (sof_count - sof_before != 1) begin
      errors++;
      $display("FAILED at %0t ns: usb_sof_o pulses got %0d expected 1",
               $time, sof_count - sof_before);
    end
    build_token(PID_OUT, DEV_ADDR, DEV_ENDP);
    drive_packet();
    build_data(PID_DATA0, 4, 1'b0, 1'b1);
    drive_packet();
    check_handshake(PID_ACK);
    wait_drained();
    report_test(5, "foreign address ignored and SOF seen");

    $display("Tests run 5, failed %0d, errors %0d", tests_failed, total_errors());
    if (total_errors() == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
design/usb_pkg.sv
design/ulpi_rx_decoder.sv
design/bulk_out_transactor.sv
design/packet_buffer.sv
design/ulpi_handshake_tx.sv
design/ulpi_bulk_out_bridge.sv
test/ulpi_bulk_out_assert.sv
test/ulpi_bulk_out_tb.sv

// ==== Makefile ====
SIM       := verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
TOP       := ulpi_bulk_out_tb
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
RUN_FLAGS := +verilator+error+limit+1000
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SOURCES)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) $(RUN_FLAGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
